//--- vlog.f
+incdir+include
hdl/ci_pkg.sv
hdl/ci_line_window.sv
hdl/ci_box_sum.sv
hdl/ci_threshold.sv
hdl/ci_top.sv
bench/ci_tb.sv

//--- include/ci_tb_model.svh
`ifndef CI_TB_MODEL_SVH
`define CI_TB_MODEL_SVH

// Sum of the window whose bottom-right corner is at (row, col).
function automatic int unsigned window_sum(
  input logic [PIX_W-1:0] img [IMG_ROWS][IMG_COLS],
  input int               row,
  input int               col
);
  int unsigned acc;
  acc = 0;
  for (int dr = 0; dr < WIN_SIZE; dr++) begin
    for (int dc = 0; dc < WIN_SIZE; dc++) begin
      acc += img[row-dr][col-dc];
    end
  end
  return acc;
endfunction

// Expected results in raster order of window centers.
// Each entry is {last, bit}.
function automatic void push_expected(
  input logic [PIX_W-1:0] img [IMG_ROWS][IMG_COLS],
  ref   logic [1:0]       exp_q [$]
);
  int unsigned sum;
  int unsigned scaled;
  logic        exp_bit;
  logic        exp_last;
  for (int r = WIN_SIZE - 1; r < IMG_ROWS; r++) begin
    for (int c = WIN_SIZE - 1; c < IMG_COLS; c++) begin
      sum      = window_sum(img, r, c);
      scaled   = img[r-WIN_RADIUS][c-WIN_RADIUS] * WIN_AREA;
      exp_bit  = (scaled >= sum);
      exp_last = (r == IMG_ROWS - 1) && (c == IMG_COLS - 1);
      exp_q.push_back({exp_last, exp_bit});
    end
  end
endfunction

`endif

//--- bench/ci_tb.sv
`timescale 1ns/1ns
`default_nettype none

module ci_tb;
  import ci_pkg::*;

  `include "ci_tb_model.svh"

  localparam int CLK_PERIOD     = 20;
  localparam int FRAME_PIX      = IMG_ROWS * IMG_COLS;
  localparam int NUM_FRAMES     = 7;
  localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_PIX * 4 + 2000;
  localparam int DRAIN_CYCLES   = FRAME_PIX;
  localparam int CORNER_IDX     = (WIN_SIZE - 1) * IMG_COLS + (WIN_SIZE - 1);
  localparam int WINS_PER_FRAME = (IMG_ROWS - WIN_SIZE + 1) * (IMG_COLS - WIN_SIZE + 1);

  logic             clk;
  logic             rst_n;
  logic             pix_valid_i;
  logic [PIX_W-1:0] pix_i;
  logic             pix_ready_o;
  logic             ci_valid_o;
  logic             ci_o;
  logic             ci_last_o;
  logic             ci_ready_i;

  logic [PIX_W-1:0] img [IMG_ROWS][IMG_COLS];
  logic [1:0]       exp_q [$];  // {last, bit}.
  logic [1:0]       exp_e;
  int               seed = 32'h891b;
  int               mismatch_errs = 0;
  int               other_errs = 0;
  int               cyc = 0;
  int               pix_acc_cnt = 0;
  int               accept_cyc = 0;
  int               frame_beats = 0;
  bit               lat_pending = 0;
  bit               check_latency = 0;
  bit               ready_random = 0;
  bit               hold_pend = 0;
  logic             hold_bit;
  logic             hold_last;
  logic             rst_d = 1'b1;
  string            test_name = "reset";

  ci_top ci_top_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .pix_valid_i (pix_valid_i),
    .pix_i       (pix_i),
    .pix_ready_o (pix_ready_o),
    .ci_valid_o  (ci_valid_o),
    .ci_o        (ci_o),
    .ci_last_o   (ci_last_o),
    .ci_ready_i  (ci_ready_i)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Sink side back-pressure.
  always @(negedge clk) begin
    ci_ready_i = ready_random ? (($random(seed) & 1) != 0) : 1'b1;
  end

  // Scoreboard and protocol checks, sampled on the rising edge.
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (!rst_d) begin
      assert (ci_valid_o === 1'b0 && ci_last_o === 1'b0) else begin
        $display("Result outputs not low during or right after reset");
        other_errs++;
      end
    end
    rst_d <= rst_n;
    if (rst_n) begin
      if (pix_valid_i && pix_ready_o) begin
        if (check_latency && (pix_acc_cnt % FRAME_PIX) == CORNER_IDX) begin
          accept_cyc  = cyc;
          lat_pending = 1'b1;
        end
        pix_acc_cnt <= pix_acc_cnt + 1;
      end
      if (ci_valid_o && lat_pending) begin
        assert (cyc - accept_cyc == 4) else begin
          $display("Mismatch test=%s latency expected 4 actual %0d", test_name, cyc - accept_cyc);
          mismatch_errs++;
        end
        lat_pending = 1'b0;
      end
      if (hold_pend) begin
        assert (ci_valid_o === 1'b1 && ci_o === hold_bit && ci_last_o === hold_last) else begin
          $display("Result changed while stalled in test %s", test_name);
          other_errs++;
        end
      end
      hold_pend = ci_valid_o && !ci_ready_i;
      hold_bit  = ci_o;
      hold_last = ci_last_o;
      if (ci_valid_o && ci_ready_i) begin
        assert (exp_q.size() != 0) else begin
          $display("Result beat arrived with no expected entry in test %s", test_name);
          other_errs++;
        end
        if (exp_q.size() != 0) begin
          exp_e = exp_q.pop_front();
          assert (ci_o === exp_e[0]) else begin
            $display("Mismatch test=%s bit expected %0b actual %0b", test_name, exp_e[0], ci_o);
            mismatch_errs++;
          end
          assert (ci_last_o === exp_e[1]) else begin
            $display("Mismatch test=%s last expected %0b actual %0b",
                     test_name, exp_e[1], ci_last_o);
            mismatch_errs++;
          end
        end
        frame_beats++;
        if (ci_last_o) begin
          assert (frame_beats == WINS_PER_FRAME) else begin
            $display("Frame in test %s ended after %0d results", test_name, frame_beats);
            other_errs++;
          end
          frame_beats = 0;
        end
      end
    end
  end

  task automatic send_pixel(input logic [PIX_W-1:0] value, input bit gaps);
    int target;
    target = pix_acc_cnt + 1;
    while (gaps && (($random(seed) & 3) == 0)) begin
      pix_valid_i = 1'b0;
      @(negedge clk);
    end
    pix_valid_i = 1'b1;
    pix_i       = value;
    do @(negedge clk); while (pix_acc_cnt != target);
    pix_valid_i = 1'b0;
  endtask

  // Queue the expected bits, then stream the image in raster order.
  task automatic send_frame(input bit gaps);
    push_expected(img, exp_q);
    for (int r = 0; r < IMG_ROWS; r++) begin
      for (int c = 0; c < IMG_COLS; c++) begin
        send_pixel(img[r][c], gaps);
      end
    end
  endtask

  task automatic fill_random();
    for (int r = 0; r < IMG_ROWS; r++) begin
      for (int c = 0; c < IMG_COLS; c++) begin
        img[r][c] = PIX_W'($random(seed));
      end
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    repeat (20) @(negedge clk);
  endtask

  initial begin
    rst_n       = 1'b0;
    pix_valid_i = 1'b0;
    pix_i       = '0;
    ci_ready_i  = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    test_name     = "random_frame";
    check_latency = 1'b1;
    fill_random();
    send_frame(1'b0);
    wait_drain();
    check_latency = 1'b0;

    test_name = "constant";
    for (int r = 0; r < IMG_ROWS; r++) begin
      for (int c = 0; c < IMG_COLS; c++) begin
        img[r][c] = 8'd255;
      end
    end
    send_frame(1'b0);
    wait_drain();

    // Horizontal ramp puts every center on its mean, one dark center breaks that.
    test_name = "gradient";
    for (int r = 0; r < IMG_ROWS; r++) begin
      for (int c = 0; c < IMG_COLS; c++) begin
        img[r][c] = PIX_W'(c * 17);
      end
    end
    img[WIN_RADIUS+1][WIN_RADIUS+1] = '0;
    send_frame(1'b0);
    wait_drain();

    test_name    = "backpressure";
    ready_random = 1'b1;
    fill_random();
    send_frame(1'b1);
    fill_random();
    send_frame(1'b1);
    wait_drain();
    ready_random = 1'b0;

    test_name = "back_to_back";
    fill_random();
    send_frame(1'b0);
    fill_random();
    send_frame(1'b0);
    wait_drain();

    assert (exp_q.size() == 0) else begin
      $display("%0d expected results were never produced", exp_q.size());
      other_errs++;
    end
    $display("Errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
    if (mismatch_errs == 0 && other_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Watchdog sized from the frame count.
  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Timeout in test %s, results stopped arriving", test_name);
    $display("Errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs + 1);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/ci_top.sv
`timescale 1ns/1ns
`default_nettype none

module ci_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     pix_valid_i,
  input  logic [ci_pkg::PIX_W-1:0] pix_i,
  output logic                     pix_ready_o,
  output logic                     ci_valid_o,
  output logic                     ci_o,
  output logic                     ci_last_o,
  input  logic                     ci_ready_i
);
  import ci_pkg::*;

  // Line window to box sum.
  logic                      col_valid;
  logic [WIN_SIZE*PIX_W-1:0] col_pix;
  logic                      col_first;
  logic                      win_full;
  logic                      win_last;
  logic                      col_ready;

  // Box sum to threshold.
  logic                      sum_valid;
  logic [SUM_W-1:0]          win_sum;
  logic [PIX_W-1:0]          center_pix;
  logic                      sum_last;
  logic                      sum_ready;

  ci_line_window ci_line_window_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .pix_valid_i (pix_valid_i),
    .pix_i       (pix_i),
    .pix_ready_o (pix_ready_o),
    .col_valid_o (col_valid),
    .col_pix_o   (col_pix),
    .col_first_o (col_first),
    .win_full_o  (win_full),
    .win_last_o  (win_last),
    .col_ready_i (col_ready)
  );

  ci_box_sum ci_box_sum_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .col_valid_i  (col_valid),
    .col_pix_i    (col_pix),
    .col_first_i  (col_first),
    .win_full_i   (win_full),
    .win_last_i   (win_last),
    .col_ready_o  (col_ready),
    .sum_valid_o  (sum_valid),
    .win_sum_o    (win_sum),
    .center_pix_o (center_pix),
    .sum_last_o   (sum_last),
    .sum_ready_i  (sum_ready)
  );

  ci_threshold ci_threshold_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .sum_valid_i  (sum_valid),
    .win_sum_i    (win_sum),
    .center_pix_i (center_pix),
    .sum_last_i   (sum_last),
    .sum_ready_o  (sum_ready),
    .ci_valid_o   (ci_valid_o),
    .ci_o         (ci_o),
    .ci_last_o    (ci_last_o),
    .ci_ready_i   (ci_ready_i)
  );

endmodule

`default_nettype wire

//--- hdl/ci_threshold.sv
`timescale 1ns/1ns
`default_nettype none

module ci_threshold (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     sum_valid_i,
  input  logic [ci_pkg::SUM_W-1:0] win_sum_i,
  input  logic [ci_pkg::PIX_W-1:0] center_pix_i,
  input  logic                     sum_last_i,
  output logic                     sum_ready_o,
  output logic                     ci_valid_o,
  output logic                     ci_o,
  output logic                     ci_last_o,
  input  logic                     ci_ready_i
);
  import ci_pkg::*;

  logic [SUM_W-1:0] scaled;
  logic             sum_acc;
  logic             ci_bit;

  assign sum_ready_o = !ci_valid_o || ci_ready_i;
  assign sum_acc     = sum_valid_i && sum_ready_o;

  // Center times window area against the window sum, same as center vs mean.
  assign scaled = SUM_W'(center_pix_i) * SUM_W'(WIN_AREA);
  assign ci_bit = (scaled >= win_sum_i);  // Equality counts as 1.

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ci_valid_o <= 1'b0;
      ci_last_o  <= 1'b0;
    end else if (sum_acc) begin
      ci_valid_o <= 1'b1;
      ci_last_o  <= sum_last_i;
    end else if (ci_ready_i) begin
      ci_valid_o <= 1'b0;
    end
  end

  // Result bit held until accepted.
  always_ff @(posedge clk) begin
    if (sum_acc) begin
      ci_o <= ci_bit;
    end
  end

endmodule

`default_nettype wire

//--- hdl/ci_box_sum.sv
`timescale 1ns/1ns
`default_nettype none

module ci_box_sum (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      col_valid_i,
  input  logic [ci_pkg::WIN_SIZE*ci_pkg::PIX_W-1:0] col_pix_i,
  input  logic                                      col_first_i,
  input  logic                                      win_full_i,
  input  logic                                      win_last_i,
  output logic                                      col_ready_o,
  output logic                                      sum_valid_o,
  output logic [ci_pkg::SUM_W-1:0]                  win_sum_o,
  output logic [ci_pkg::PIX_W-1:0]                  center_pix_o,
  output logic                                      sum_last_o,
  input  logic                                      sum_ready_i
);
  import ci_pkg::*;

  logic                 col_acc;
  logic [COL_SUM_W-1:0] col_add;

  // Stage one slot.
  logic                 s1_valid;
  logic                 s1_first;
  logic                 s1_full;
  logic                 s1_last;
  logic [COL_SUM_W-1:0] s1_col_sum;
  logic [PIX_W-1:0]     s1_mid;
  logic                 s1_take;

  // Stage two state.
  logic                 s2_ready;
  logic [COL_SUM_W-1:0] colsum_sr [WIN_SIZE];
  logic [PIX_W-1:0]     mid_sr [WIN_RADIUS];
  logic [SUM_W-1:0]     run_sum;
  logic [SUM_W-1:0]     sum_next;

  assign s2_ready = !sum_valid_o || sum_ready_i;

  // Columns outside a full window never need the output slot.
  assign s1_take     = s1_valid && (s2_ready || !s1_full);
  assign col_ready_o = !s1_valid || s1_take;
  assign col_acc     = col_valid_i && col_ready_o;

  always_comb begin
    col_add = '0;
    for (int r = 0; r < WIN_SIZE; r++) begin
      col_add = col_add + COL_SUM_W'(col_pix_i[r*PIX_W +: PIX_W]);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s1_first <= 1'b0;
      s1_full  <= 1'b0;
      s1_last  <= 1'b0;
    end else if (col_acc) begin
      s1_valid <= 1'b1;
      s1_first <= col_first_i;
      s1_full  <= win_full_i;
      s1_last  <= win_last_i;
    end else if (s1_take) begin
      s1_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (col_acc) begin
      s1_col_sum <= col_add;
      s1_mid     <= col_pix_i[WIN_RADIUS*PIX_W +: PIX_W];  // Middle row of the column.
    end
  end

  // Sliding box sum, restarted at the first column of each row.
  always_comb begin
    if (s1_first) begin
      sum_next = SUM_W'(s1_col_sum);
    end else begin
      sum_next = run_sum + SUM_W'(s1_col_sum) - SUM_W'(colsum_sr[WIN_SIZE-1]);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      run_sum <= '0;
      for (int i = 0; i < WIN_SIZE; i++) begin
        colsum_sr[i] <= '0;
      end
    end else if (s1_take) begin
      run_sum      <= sum_next;
      colsum_sr[0] <= s1_col_sum;
      for (int i = 1; i < WIN_SIZE; i++) begin
        colsum_sr[i] <= s1_first ? '0 : colsum_sr[i-1];  // Nothing to drop on a new row.
      end
    end
  end

  // Middle pixels of the previous columns.
  always_ff @(posedge clk) begin
    if (s1_take) begin
      mid_sr[0] <= s1_mid;
      for (int i = 1; i < WIN_RADIUS; i++) begin
        mid_sr[i] <= mid_sr[i-1];
      end
    end
  end

  // Output slot, loaded only by full-window columns.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sum_valid_o <= 1'b0;
      sum_last_o  <= 1'b0;
    end else if (s1_take && s1_full) begin
      sum_valid_o <= 1'b1;
      sum_last_o  <= s1_last;
    end else if (sum_ready_i) begin
      sum_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_take && s1_full) begin
      win_sum_o    <= sum_next;
      center_pix_o <= mid_sr[WIN_RADIUS-1];  // Six columns back.
    end
  end

endmodule

`default_nettype wire

//--- hdl/ci_line_window.sv
`timescale 1ns/1ns
`default_nettype none

module ci_line_window (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      pix_valid_i,
  input  logic [ci_pkg::PIX_W-1:0]                  pix_i,
  output logic                                      pix_ready_o,
  output logic                                      col_valid_o,
  output logic [ci_pkg::WIN_SIZE*ci_pkg::PIX_W-1:0] col_pix_o,
  output logic                                      col_first_o,
  output logic                                      win_full_o,
  output logic                                      win_last_o,
  input  logic                                      col_ready_i
);
  import ci_pkg::*;

  logic [COL_IDX_W-1:0] col_cnt;
  logic [ROW_IDX_W-1:0] row_cnt;
  logic                 pix_acc;
  logic                 at_row_end;
  logic                 at_frame_end;
  logic                 at_first_col;
  logic                 in_full_win;

  // Previous 12 lines, entry 0 is the oldest line.
  logic [PIX_W-1:0] line_mem [WIN_SIZE-1][IMG_COLS];

  assign pix_ready_o = !col_valid_o || col_ready_i;
  assign pix_acc     = pix_valid_i && pix_ready_o;

  assign at_row_end   = (col_cnt == COL_IDX_W'(IMG_COLS - 1));
  assign at_frame_end = at_row_end && (row_cnt == ROW_IDX_W'(IMG_ROWS - 1));
  assign at_first_col = (col_cnt == '0);

  // Bottom-right corner of a window that lies inside the frame.
  assign in_full_win = (row_cnt >= ROW_IDX_W'(WIN_SIZE - 1)) &&
                       (col_cnt >= COL_IDX_W'(WIN_SIZE - 1));

  // Raster position of the incoming pixel.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_cnt <= '0;
      row_cnt <= '0;
    end else if (pix_acc) begin
      if (at_row_end) begin
        col_cnt <= '0;
        if (at_frame_end) begin
          row_cnt <= '0;  // Next frame starts right away.
        end else begin
          row_cnt <= row_cnt + 1'b1;
        end
      end else begin
        col_cnt <= col_cnt + 1'b1;
      end
    end
  end

  // Line chain shifts up by one line in the current column.
  always_ff @(posedge clk) begin
    if (pix_acc) begin
      for (int l = 0; l < WIN_SIZE - 2; l++) begin
        line_mem[l][col_cnt] <= line_mem[l+1][col_cnt];
      end
      line_mem[WIN_SIZE-2][col_cnt] <= pix_i;
    end
  end

  // Column payload, newest pixel in the top slice.
  always_ff @(posedge clk) begin
    if (pix_acc) begin
      for (int l = 0; l < WIN_SIZE - 1; l++) begin
        col_pix_o[l*PIX_W +: PIX_W] <= line_mem[l][col_cnt];
      end
      col_pix_o[(WIN_SIZE-1)*PIX_W +: PIX_W] <= pix_i;
    end
  end

  // Output slot control and position flags.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_valid_o <= 1'b0;
      col_first_o <= 1'b0;
      win_full_o  <= 1'b0;
      win_last_o  <= 1'b0;
    end else if (pix_acc) begin
      col_valid_o <= 1'b1;
      col_first_o <= at_first_col;
      win_full_o  <= in_full_win;
      win_last_o  <= at_frame_end;
    end else if (col_ready_i) begin
      col_valid_o <= 1'b0;  // Held beat taken.
    end
  end

endmodule

`default_nettype wire

//--- hdl/ci_pkg.sv
`timescale 1ns/1ns
`default_nettype none

package ci_pkg;

  // Pixel format.
  localparam int PIX_W = 8;

  // Frame geometry, fixed at build time.
  localparam int IMG_COLS = 15;
  localparam int IMG_ROWS = 15;

  // Center-intensity window.
  localparam int WIN_RADIUS = 6;
  localparam int WIN_SIZE   = 2 * WIN_RADIUS + 1;
  localparam int WIN_AREA   = WIN_SIZE * WIN_SIZE;  // Scale factor for the center.

  // Arithmetic widths.
  localparam int COL_SUM_W = 12;  // 13 * 255 fits.
  localparam int SUM_W     = 16;  // 169 * 255 fits.

  // Raster counters.
  localparam int COL_IDX_W = 4;
  localparam int ROW_IDX_W = 4;

endpackage

`default_nettype wire
